// File: all.f
verilog/rv_pkg.sv
verilog/rv_issue_queue.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_branch.sv
verilog/rv_execute.sv
verilog/rv_core_top.sv
bench/rv_checker.sv
bench/tb_top.sv

// File: bench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import rv_pkg::*;

    localparam int N_RANDOM   = 200;
    localparam int WAIT_LIMIT = 2000;
    localparam int HOLD_FROM  = 40; // Consumer withholds retire credits in this window.
    localparam int HOLD_TO    = 100;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    instr_t      in_data;
    logic        in_credit;
    logic        retire_valid;
    retire_t     retire_data;
    logic        retire_credit;
    int          seed;
    int          delay_seed;
    int          credits;
    int          owed;
    int          delay;
    int          cycle;
    int          waited;
    int          bench_errors;
    int          accepted;
    int          retired;
    int          credit_pulses;
    int          data_errors;
    int          protocol_errors;
    logic        timed_out;
    logic [31:0] send_pc;
    logic [31:0] program_q [$];

    rv_core_top rv_core_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_credit     (in_credit),
        .retire_valid  (retire_valid),
        .retire_data   (retire_data),
        .retire_credit (retire_credit)
    );

    rv_checker u_checker (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_data         (in_data),
        .in_credit       (in_credit),
        .retire_valid    (retire_valid),
        .retire_data     (retire_data),
        .retire_credit   (retire_credit),
        .accepted        (accepted),
        .retired         (retired),
        .credit_pulses   (credit_pulses),
        .data_errors     (data_errors),
        .protocol_errors (protocol_errors)
    );

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // Random legal encodings use only x0..x7 so that dependencies are frequent.
    function automatic logic [31:0] random_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          kind;
        rd   = {2'b0, 3'($random(seed))};
        rs1  = {2'b0, 3'($random(seed))};
        rs2  = {2'b0, 3'($random(seed))};
        f3   = 3'($random(seed));
        imm  = 12'($random(seed));
        kind = {$random(seed)} % 6;
        case (kind)
            0: return enc_r(((f3 == 3'd0 || f3 == 3'd5) && imm[0]) ? 7'h20 : 7'h00,
                            rs2, rs1, f3, rd);
            1: begin
                if (f3 == 3'd1) imm[11:5] = 7'h00;
                if (f3 == 3'd5) imm[11:5] = {1'b0, imm[10], 5'b0};
                return enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
            end
            2: return {imm, rs1, f3, rd, f3[0] ? OPC_LUI : OPC_AUIPC};
            3: begin
                if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;
                return enc_b({imm, 1'b0}, rs2, rs1, f3);
            end
            4: return enc_j({imm, rs1, f3, 1'b0}, rd);
            default: return enc_i(imm, rs1, 3'd0, rd, OPC_JALR);
        endcase
    endfunction

    task automatic build_program();
        program_q = {enc_i(12'hffb, 0, 0, 1, OPC_OP_IMM), enc_i(12'd100, 1, 0, 2, OPC_OP_IMM),
                     {20'h80000, 5'd3, OPC_LUI}, {20'h12345, 5'd4, OPC_AUIPC}};
        program_q = {program_q, enc_r(0, 2, 1, 0, 5), enc_r(7'h20, 2, 1, 0, 6),
                     enc_r(0, 1, 2, 1, 7), enc_r(0, 2, 1, 2, 8), enc_r(0, 2, 1, 3, 9)};
        program_q = {program_q, enc_r(0, 3, 1, 4, 10), enc_r(0, 2, 3, 5, 11),
                     enc_r(7'h20, 2, 3, 5, 12), enc_r(0, 2, 1, 6, 13), enc_r(0, 2, 1, 7, 14)};
        program_q = {program_q, enc_i(12'hffc, 1, 2, 15, OPC_OP_IMM),
                     enc_i(12'hffc, 1, 3, 16, OPC_OP_IMM), enc_i(12'h555, 2, 4, 17, OPC_OP_IMM),
                     enc_i(12'hf00, 2, 6, 18, OPC_OP_IMM), enc_i(12'h0f0, 1, 7, 19, OPC_OP_IMM)};
        program_q = {program_q, enc_i(12'h003, 2, 1, 20, OPC_OP_IMM),
                     enc_i(12'h004, 3, 5, 21, OPC_OP_IMM), enc_i(12'h404, 3, 5, 22, OPC_OP_IMM),
                     enc_i(12'h001, 1, 0, 0, OPC_OP_IMM), enc_r(0, 2, 1, 0, 0)}; // x0 writes.
        program_q = {program_q, enc_b(13'd16, 1, 1, 0), enc_b(13'h1ff8, 1, 1, 1),
                     enc_b(13'd32, 2, 1, 4), enc_b(13'd32, 2, 1, 5),
                     enc_b(13'd64, 2, 1, 6), enc_b(13'h1fc0, 2, 1, 7)};
        program_q = {program_q, enc_j(21'd2048, 23), enc_j(21'h1ffff4, 0),
                     enc_i(12'd8, 2, 0, 24, OPC_JALR), enc_i(12'hfff, 24, 0, 24, OPC_JALR)};
        program_q = {program_q, enc_i(12'd4, 1, 2, 25, OPC_LOAD), enc_i(12'd0, 1, 4, 25, OPC_LOAD),
                     {7'h00, 5'd2, 5'd1, 3'd2, 5'd8, OPC_STORE}, 32'h0000_0000, 32'hffff_ffff};
        program_q = {program_q, enc_r(7'h20, 2, 1, 1, 5), enc_i(12'd0, 1, 1, 5, OPC_JALR),
                     enc_b(13'd8, 2, 1, 2), enc_i(12'h400, 1, 1, 5, OPC_OP_IMM)};
        program_q = {program_q, enc_i(12'd1, 26, 0, 26, OPC_OP_IMM),
                     enc_i(12'd1, 26, 0, 26, OPC_OP_IMM), enc_i(12'd1, 26, 0, 26, OPC_OP_IMM),
                     enc_r(0, 26, 26, 0, 27), enc_r(0, 27, 26, 1, 28)}; // Dependent chain.
        for (int k = 0; k < N_RANDOM; k++) begin
            program_q.push_back(random_instr());
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        timed_out = 1'b1;
        bench_errors++;
    endtask

    task automatic tick();
        @(negedge clk);
        if (in_credit) credits++; // Returned issue credit.
    endtask

    task automatic send_instr(input logic [31:0] word);
        int wait_cnt;
        wait_cnt = 0;
        if (($random(seed) & 7) == 0) begin
            in_valid = 1'b0;
            tick();
        end
        while (credits == 0 && !timed_out) begin
            in_valid = 1'b0;
            tick();
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT) report_timeout("no issue credit came back");
        end
        if (!timed_out) begin
            in_valid      = 1'b1;
            in_data.instr = word;
            in_data.pc    = send_pc;
            credits--;
            send_pc += 32'd4;
            tick();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Consumer returns one retire credit per record after a random delay.
    initial begin
        retire_credit = 1'b0;
        delay_seed    = 32'h33d4;
        owed          = 0;
        delay         = 0;
        cycle         = 0;
        forever begin
            @(negedge clk);
            cycle++;
            if (retire_valid) owed++;
            retire_credit = 1'b0;
            if (cycle >= HOLD_FROM && cycle < HOLD_TO) begin
                delay = 0;
            end else if (owed > 0 && delay == 0) begin
                retire_credit = 1'b1;
                owed--;
                delay = {$random(delay_seed)} % 4;
            end else if (delay > 0) begin
                delay--;
            end
        end
    end

    initial begin
        seed         = 32'h33d4;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        credits      = QUEUE_DEPTH;
        send_pc      = 32'h0000_1000;
        bench_errors = 0;
        timed_out    = 1'b0;
        build_program();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (program_q[k]) begin
            if (!timed_out) begin
                send_instr(program_q[k]);
            end
        end
        in_valid = 1'b0;
        waited   = 0;
        while (!timed_out && retired < program_q.size() && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!timed_out && retired < program_q.size()) begin
            report_timeout("retire stream did not drain");
        end
        if (credit_pulses != accepted) begin
            $display("Fail issue_credits: expected %0d actual %0d", accepted, credit_pulses);
            bench_errors++;
        end
        $display("Errors: data %0d, protocol %0d", data_errors, protocol_errors + bench_errors);
        if (data_errors == 0 && protocol_errors + bench_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/rv_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv_checker (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  rv_pkg::instr_t  in_data,
    input  logic            in_credit,
    input  logic            retire_valid,
    input  rv_pkg::retire_t retire_data,
    input  logic            retire_credit,
    output int              accepted,
    output int              retired,
    output int              credit_pulses,
    output int              data_errors,
    output int              protocol_errors
);
    import rv_pkg::*;

    logic [31:0] model_regs [32];
    retire_t     expected_q [$];
    string       names_q [$];
    string       test_name;
    int          credits_returned;

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << y[4:0];
            3'd2: return {31'b0, $signed(x) < $signed(y)};
            3'd3: return {31'b0, x < y};
            3'd4: return x ^ y;
            3'd5: begin
                if (alt) return $unsigned($signed(x) >>> y[4:0]);
                return x >> y[4:0];
            end
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction

    // ISA model of one instruction, updates the model register file.
    function automatic retire_t ref_execute(input instr_t in, output string name);
        retire_t     r;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] res;
        logic [2:0]  f3;
        logic        writes;
        logic        taken;
        w      = in.instr;
        f3     = w[14:12];
        a      = model_regs[w[19:15]];
        b      = model_regs[w[24:20]];
        imm_i  = {{20{w[31]}}, w[31:20]};
        imm_b  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        res    = '0;
        writes = 1'b0;
        taken  = 1'b0;
        r      = '0;
        r.pc      = in.pc;
        r.rd      = w[11:7];
        r.next_pc = in.pc + 32'd4;
        r.illegal = 1'b1;
        name      = "illegal";
        case (w[6:0])
            7'h33: if (!w[30] || f3 == 3'd0 || f3 == 3'd5) begin
                name   = "op_reg";
                writes = 1'b1;
                res    = alu_ref(f3, w[30], a, b);
            end
            7'h13: if (f3 != 3'd1 || !w[30]) begin
                name   = "op_imm";
                writes = 1'b1;
                res    = alu_ref(f3, w[30] && f3 == 3'd5, a, imm_i); // Only SRAI uses bit 30.
            end
            7'h37: begin
                name   = "lui";
                writes = 1'b1;
                res    = {w[31:12], 12'b0};
            end
            7'h17: begin
                name   = "auipc";
                writes = 1'b1;
                res    = in.pc + {w[31:12], 12'b0};
            end
            7'h63: if (f3 != 3'd2 && f3 != 3'd3) begin
                name      = "branch";
                r.illegal = 1'b0;
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) r.next_pc = in.pc + imm_b;
            end
            7'h6f: begin
                name      = "jal";
                writes    = 1'b1;
                res       = in.pc + 32'd4;
                r.next_pc = in.pc + imm_j;
            end
            7'h67: if (f3 == 3'd0) begin
                name      = "jalr";
                writes    = 1'b1;
                res       = in.pc + 32'd4;
                r.next_pc = (a + imm_i) & ~32'd1;
            end
            7'h03, 7'h23: name = "load_store";
            default: ;
        endcase
        if (writes) r.illegal = 1'b0;
        r.rd_we = writes && (w[11:7] != 5'd0);
        if (r.rd_we) begin
            r.rd_value          = res;
            model_regs[w[11:7]] = res;
        end
        name = $sformatf("%s_%08h", name, in.pc);
        return r;
    endfunction

    task automatic check_field(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %08h actual %08h", test, field, exp, act);
            data_errors++;
        end
    endtask

    task automatic compare_record(input retire_t exp, input retire_t act, input string test);
        check_field(test, "pc", exp.pc, act.pc);
        check_field(test, "rd_we", 32'(exp.rd_we), 32'(act.rd_we));
        check_field(test, "illegal", 32'(exp.illegal), 32'(act.illegal));
        check_field(test, "next_pc", exp.next_pc, act.next_pc);
        if (exp.rd_we) begin
            check_field(test, "rd", 32'(exp.rd), 32'(act.rd));
            check_field(test, "rd_value", exp.rd_value, act.rd_value);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            accepted         = 0;
            retired          = 0;
            credit_pulses    = 0;
            credits_returned = 0;
            data_errors      = 0;
            protocol_errors  = 0;
            expected_q.delete();
            names_q.delete();
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
        end else begin
            if (in_credit) credit_pulses++;
            if (retire_credit) credits_returned++;
            if (in_valid) begin
                accepted++;
                expected_q.push_back(ref_execute(in_data, test_name));
                names_q.push_back(test_name);
                if (accepted - credit_pulses > QUEUE_DEPTH) begin
                    $display("Error: instruction sent into a full issue queue");
                    protocol_errors++;
                end
            end
            if (retire_valid) begin
                retired++;
                if (retired - credits_returned > RETIRE_CREDITS) begin
                    $display("Error: retire record sent without a retire credit");
                    protocol_errors++;
                end
                if (expected_q.size() == 0) begin
                    $display("Error: retire record with no instruction outstanding");
                    protocol_errors++;
                end else begin
                    compare_record(expected_q.pop_front(), retire_data, names_q.pop_front());
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  rv_pkg::instr_t  in_data,
    output logic            in_credit,
    output logic            retire_valid,
    output rv_pkg::retire_t retire_data,
    input  logic            retire_credit
);
    import rv_pkg::*;

    instr_t          head;
    logic            head_valid;
    logic            pop;
    decoded_t        dec;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [XLEN-1:0] rf_wdata;

    rv_issue_queue u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid),
        .in_credit  (in_credit)
    );

    rv_decode u_decode (
        .instr (head.instr),
        .dec   (dec)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    rv_execute u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .head_valid    (head_valid),
        .head_pc       (head.pc),
        .dec           (dec),
        .rdata1        (rdata1),
        .rdata2        (rdata2),
        .pop           (pop),
        .we            (rf_we),
        .waddr         (rf_waddr),
        .wdata         (rf_wdata),
        .retire_valid  (retire_valid),
        .retire_data   (retire_data),
        .retire_credit (retire_credit)
    );

endmodule

`default_nettype wire

// File: verilog/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             head_valid,
    input  logic [31:0]      head_pc,
    input  rv_pkg::decoded_t dec,
    input  logic [31:0]      rdata1,
    input  logic [31:0]      rdata2,
    output logic             pop,
    output logic             we,
    output logic [4:0]       waddr,
    output logic [31:0]      wdata,
    output logic             retire_valid,
    output rv_pkg::retire_t  retire_data,
    input  logic             retire_credit
);
    import rv_pkg::*;

    logic              ex_valid;
    logic [XLEN-1:0]   ex_pc;
    op_e               ex_op;
    logic [4:0]        ex_rd;
    logic              ex_rd_valid;
    logic              ex_use_imm;
    logic [XLEN-1:0]   ex_a;
    logic [XLEN-1:0]   ex_b;
    logic [XLEN-1:0]   ex_imm;
    logic [RCNT_W-1:0] credit_cnt;
    logic [RCNT_W-1:0] credit_avail;
    logic              fire;
    logic [XLEN-1:0]   alu_b;
    logic [XLEN-1:0]   alu_result;
    logic [XLEN-1:0]   next_pc;
    logic [XLEN-1:0]   link;
    logic              illegal;
    logic              rd_we;
    logic [XLEN-1:0]   rd_value;

    // The record going out this cycle already holds one credit.
    assign credit_avail = credit_cnt - RCNT_W'(retire_valid);
    assign fire         = ex_valid && (credit_avail != '0);
    assign pop          = head_valid && (!ex_valid || fire);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (pop) begin
            ex_valid <= 1'b1;
        end else if (fire) begin
            ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            ex_pc       <= head_pc;
            ex_op       <= dec.op;
            ex_rd       <= dec.rd;
            ex_rd_valid <= dec.rd_valid;
            ex_use_imm  <= dec.fmt inside {FMT_I, FMT_U};
            ex_a        <= dec.rs1_valid ? rdata1 : '0;
            ex_b        <= dec.rs2_valid ? rdata2 : '0;
            ex_imm      <= dec.imm;
        end
    end

    assign alu_b = ex_use_imm ? ex_imm : ex_b;

    rv_alu u_alu (
        .op     (ex_op),
        .a      (ex_a),
        .b      (alu_b),
        .pc     (ex_pc),
        .result (alu_result)
    );

    rv_branch u_branch (
        .op      (ex_op),
        .a       (ex_a),
        .b       (ex_b),
        .pc      (ex_pc),
        .imm     (ex_imm),
        .next_pc (next_pc),
        .link    (link)
    );

    // No data memory, so loads and stores retire as illegal.
    assign illegal  = (ex_op == OP_ILLEGAL) || (ex_op inside {[OP_LB:OP_SW]});
    assign rd_we    = ex_rd_valid && (ex_rd != 5'd0) && !illegal;
    assign rd_value = !rd_we ? '0 : (ex_op inside {OP_JAL, OP_JALR}) ? link : alu_result;

    assign we    = fire && rd_we;
    assign waddr = ex_rd;
    assign wdata = rd_value;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            credit_cnt   <= RCNT_W'(RETIRE_CREDITS);
        end else begin
            retire_valid <= fire;
            credit_cnt   <= credit_cnt - RCNT_W'(retire_valid) + RCNT_W'(retire_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            retire_data.pc       <= ex_pc;
            retire_data.rd       <= ex_rd;
            retire_data.rd_we    <= rd_we;
            retire_data.rd_value <= rd_value;
            retire_data.next_pc  <= next_pc;
            retire_data.illegal  <= illegal;
        end
    end

    // Consumer returns no more credits than were handed out.
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= RETIRE_CREDITS);

    a_retire_on_credit: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> (credit_cnt != '0));

endmodule

`default_nettype wire

// File: verilog/rv_branch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_branch (
    input  rv_pkg::op_e op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [31:0] pc,
    input  logic [31:0] imm,
    output logic [31:0] next_pc,
    output logic [31:0] link
);
    import rv_pkg::*;

    logic        taken;
    logic [31:0] jalr_target;

    assign link        = pc + 32'd4;
    assign jalr_target = (a + imm) & ~32'd1;

    always_comb begin
        case (op)
            OP_BEQ:  taken = (a == b);
            OP_BNE:  taken = (a != b);
            OP_BLT:  taken = ($signed(a) < $signed(b));
            OP_BGE:  taken = ($signed(a) >= $signed(b));
            OP_BLTU: taken = (a < b);
            OP_BGEU: taken = (a >= b);
            OP_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase

        if (op == OP_JALR) begin
            next_pc = jalr_target;
        end else if (taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = link; // Fall through.
        end
    end

endmodule

`default_nettype wire

// File: verilog/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  rv_pkg::op_e op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [31:0] pc,
    output logic [31:0] result
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            OP_ADD, OP_ADDI:   result = a + b;
            OP_SUB:            result = a - b;
            OP_SLL, OP_SLLI:   result = a << shamt;
            OP_SLT, OP_SLTI:   result = {31'b0, $signed(a) < $signed(b)};
            OP_SLTU, OP_SLTIU: result = {31'b0, a < b};
            OP_XOR, OP_XORI:   result = a ^ b;
            OP_SRL, OP_SRLI:   result = a >> shamt;
            OP_SRA, OP_SRAI:   result = $unsigned($signed(a) >>> shamt);
            OP_OR, OP_ORI:     result = a | b;
            OP_AND, OP_ANDI:   result = a & b;
            OP_LUI:            result = b;
            OP_AUIPC:          result = pc + b;
            default:           result = '0; // Branches, jumps and memory ops.
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [1:31]; // x0 is not stored.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Same-cycle write is forwarded to the reader.
    always_comb begin
        rdata1 = (raddr1 == 5'd0) ? '0 : (we && (waddr == raddr1)) ? wdata : regs[raddr1];
        rdata2 = (raddr2 == 5'd0) ? '0 : (we && (waddr == raddr2)) ? wdata : regs[raddr2];
    end

endmodule

`default_nettype wire

// File: verilog/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  logic [31:0]      instr,
    output rv_pkg::decoded_t dec
);
    import rv_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        f7_b30;
    fmt_e        fmt;
    op_e         op;
    logic [31:0] imm;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign f7_b30 = instr[30];

    always_comb begin
        case (opcode)
            OPC_OP:                        fmt = FMT_R;
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: fmt = FMT_I;
            OPC_STORE:                     fmt = FMT_S;
            OPC_BRANCH:                    fmt = FMT_B;
            OPC_LUI, OPC_AUIPC:            fmt = FMT_U;
            OPC_JAL:                       fmt = FMT_J;
            default:                       fmt = FMT_NONE;
        endcase

        case (fmt)
            FMT_I:   imm = {{20{instr[31]}}, instr[31:20]};
            FMT_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            FMT_B:   imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            FMT_U:   imm = {instr[31:12], 12'b0};
            FMT_J:   imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase

        op = OP_ILLEGAL;
        case (opcode)
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  op = OP_LB;
                    3'b001:  op = OP_LH;
                    3'b010:  op = OP_LW;
                    3'b100:  op = OP_LBU;
                    3'b101:  op = OP_LHU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  op = OP_SB;
                    3'b001:  op = OP_SH;
                    3'b010:  op = OP_SW;
                    default: op = OP_ILLEGAL;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000:  op = OP_ADDI;
                    3'b010:  op = OP_SLTI;
                    3'b011:  op = OP_SLTIU;
                    3'b100:  op = OP_XORI;
                    3'b110:  op = OP_ORI;
                    3'b111:  op = OP_ANDI;
                    3'b001:  op = f7_b30 ? OP_ILLEGAL : OP_SLLI;
                    default: op = f7_b30 ? OP_SRAI : OP_SRLI;
                endcase
            end
            OPC_OP: begin
                case ({f7_b30, funct3})
                    4'b0_000: op = OP_ADD;
                    4'b1_000: op = OP_SUB;
                    4'b0_001: op = OP_SLL;
                    4'b0_010: op = OP_SLT;
                    4'b0_011: op = OP_SLTU;
                    4'b0_100: op = OP_XOR;
                    4'b0_101: op = OP_SRL;
                    4'b1_101: op = OP_SRA;
                    4'b0_110: op = OP_OR;
                    4'b0_111: op = OP_AND;
                    default:  op = OP_ILLEGAL;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            OPC_LUI:   op = OP_LUI;
            OPC_AUIPC: op = OP_AUIPC;
            OPC_JAL:   op = OP_JAL;
            OPC_JALR:  op = (funct3 == 3'b000) ? OP_JALR : OP_ILLEGAL;
            default:   op = OP_ILLEGAL;
        endcase

        dec.op        = op;
        dec.fmt       = fmt;
        dec.rs1       = instr[19:15];
        dec.rs2       = instr[24:20];
        dec.rd        = instr[11:7];
        dec.rs1_valid = fmt inside {FMT_R, FMT_I, FMT_S, FMT_B};
        dec.rs2_valid = fmt inside {FMT_R, FMT_S, FMT_B};
        dec.rd_valid  = fmt inside {FMT_R, FMT_I, FMT_U, FMT_J};
        dec.imm       = imm;
    end

endmodule

`default_nettype wire

// File: verilog/rv_issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module rv_issue_queue (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    input  rv_pkg::instr_t in_data,
    input  logic           pop,
    output rv_pkg::instr_t head,
    output logic           head_valid,
    output logic           in_credit
);
    import rv_pkg::*;

    instr_t            mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QPTR_W:0]   count;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            in_credit <= pop; // One credit back per consumed entry.
        end
    end

    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

    // The sender only sends on a credit, so a full queue never sees in_valid.
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> (count < QUEUE_DEPTH));

endmodule

`default_nettype wire

// File: verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN           = 32;
    localparam int QUEUE_DEPTH    = 4;
    localparam int RETIRE_CREDITS = 2;
    localparam int QPTR_W         = $clog2(QUEUE_DEPTH);
    localparam int RCNT_W         = $clog2(RETIRE_CREDITS + 1);

    // Major opcodes, full 7 bits so that compressed encodings fall out as illegal.
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef enum logic [5:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
        OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LUI, OP_AUIPC,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ILLEGAL
    } op_e;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE
    } fmt_e;

    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
    } instr_t;

    typedef struct packed {
        op_e             op;
        fmt_e            fmt;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic            rs1_valid;
        logic            rs2_valid;
        logic            rd_valid;
        logic [XLEN-1:0] imm;
    } decoded_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic            rd_we;
        logic [XLEN-1:0] rd_value;
        logic [XLEN-1:0] next_pc;
        logic            illegal;
    } retire_t;

endpackage

`default_nettype wire
